//--- include/rvseed_config.svh
`ifndef RVSEED_CONFIG_SVH
`define RVSEED_CONFIG_SVH

// datapath width of the RV64 core
`define RVSEED_XLEN 64

// micro-op queue entries between decoder and executor
`define RVSEED_FIFO_DEPTH 4

// architectural integer registers
`define RVSEED_NUM_REGS 32

// data memory size in doublewords
`define RVSEED_DMEM_WORDS 16

`endif

//--- hw/rvseed_pkg.sv
`include "rvseed_config.svh"

package rvseed_pkg;

    typedef logic [`RVSEED_XLEN-1:0] xlen_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0] reg_idx_t;
    typedef logic [3:0] alu_op_t;
    typedef logic [1:0] mem_size_t;

    localparam alu_op_t ALU_ADD  = 4'b0011;
    localparam alu_op_t ALU_SUB  = 4'b0100;
    localparam alu_op_t ALU_ADDW = 4'b0101;
    localparam alu_op_t ALU_SLTU = 4'b1001;
    localparam alu_op_t ALU_SRA  = 4'b0110;
    localparam alu_op_t ALU_AND  = 4'b0111;
    localparam alu_op_t ALU_XOR  = 4'b1000;
    localparam alu_op_t ALU_SLL  = 4'b1010;
    localparam alu_op_t ALU_REMU = 4'b1011;

    // load size follows the log2 byte count of the funct3 encoding
    localparam mem_size_t SIZE_B = 2'd0;
    localparam mem_size_t SIZE_W = 2'd2;
    localparam mem_size_t SIZE_D = 2'd3;

    typedef struct packed {
        alu_op_t   alu_op;
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        reg_idx_t  rd;
        xlen_t     imm;
        logic      use_imm;  // second operand is imm instead of rs2
        logic      wr_en;    // never set when rd is x0
        logic      is_load;
        logic      is_store;
        mem_size_t mem_size;
    } uop_t;

    typedef struct packed {
        reg_idx_t rd;
        xlen_t    data;
    } wb_t;

    typedef enum logic {
        EXEC_IDLE,
        EXEC_RUN
    } exec_state_e;

endpackage

//--- hw/inst_decoder.sv
`timescale 1ns/1ps
`include "rvseed_config.svh"

module inst_decoder (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                inst_valid,
    input  rvseed_pkg::inst_t   inst,
    output logic                uop_valid,
    output rvseed_pkg::uop_t    uop,
    output logic                illegal_inst
);

    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_32  = 7'b0111011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    rvseed_pkg::xlen_t imm_i;
    rvseed_pkg::xlen_t imm_s;
    rvseed_pkg::uop_t  dec;
    logic              legal;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign imm_i  = {{(`RVSEED_XLEN-12){inst[31]}}, inst[31:20]};
    assign imm_s  = {{(`RVSEED_XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};

    always_comb begin
        dec          = '0;
        legal        = 1'b0;
        dec.rs1      = inst[19:15];
        dec.rs2      = inst[24:20];
        dec.rd       = inst[11:7];
        dec.alu_op   = rvseed_pkg::ALU_ADD;  // also the address adder for loads and stores
        dec.mem_size = rvseed_pkg::SIZE_D;
        case (opcode)
            OPC_OP_IMM: begin
                legal       = (funct3 == 3'b000);  // ADDI only
                dec.use_imm = 1'b1;
                dec.imm     = imm_i;
                dec.wr_en   = 1'b1;
            end
            OPC_OP: begin
                legal     = 1'b1;
                dec.wr_en = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: dec.alu_op = rvseed_pkg::ALU_ADD;
                    10'b0100000_000: dec.alu_op = rvseed_pkg::ALU_SUB;
                    10'b0000000_001: dec.alu_op = rvseed_pkg::ALU_SLL;
                    10'b0000000_011: dec.alu_op = rvseed_pkg::ALU_SLTU;
                    10'b0000000_100: dec.alu_op = rvseed_pkg::ALU_XOR;
                    10'b0100000_101: dec.alu_op = rvseed_pkg::ALU_SRA;
                    10'b0000000_111: dec.alu_op = rvseed_pkg::ALU_AND;
                    10'b0000001_111: dec.alu_op = rvseed_pkg::ALU_REMU;
                    default:         legal = 1'b0;
                endcase
            end
            OPC_OP_32: begin
                legal      = ({funct7, funct3} == 10'b0000000_000);  // ADDW only
                dec.alu_op = rvseed_pkg::ALU_ADDW;
                dec.wr_en  = 1'b1;
            end
            OPC_LOAD: begin
                dec.use_imm = 1'b1;
                dec.imm     = imm_i;
                dec.wr_en   = 1'b1;
                dec.is_load = 1'b1;
                case (funct3)
                    3'b100: begin
                        legal        = 1'b1;
                        dec.mem_size = rvseed_pkg::SIZE_B;
                    end
                    3'b110: begin
                        legal        = 1'b1;
                        dec.mem_size = rvseed_pkg::SIZE_W;
                    end
                    3'b011:  legal = 1'b1;
                    default: legal = 1'b0;
                endcase
            end
            OPC_STORE: begin
                legal        = (funct3 == 3'b011);  // SD only
                dec.use_imm  = 1'b1;
                dec.imm      = imm_s;
                dec.is_store = 1'b1;
            end
            default: legal = 1'b0;
        endcase
        if (dec.rd == '0) begin
            dec.wr_en = 1'b0;  // the executor relies on this and never checks rd again
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            uop_valid    <= 1'b0;
            illegal_inst <= 1'b0;
            uop          <= '0;
        end else begin
            uop_valid    <= inst_valid && legal;
            illegal_inst <= inst_valid && !legal;
            if (inst_valid) begin
                uop <= dec;
            end
        end
    end

endmodule

//--- hw/uop_fifo.sv
`timescale 1ns/1ps
`include "rvseed_config.svh"

module uop_fifo (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             push,
    input  rvseed_pkg::uop_t push_data,
    input  logic             pop,
    output rvseed_pkg::uop_t head,
    output logic             empty,
    output logic             full
);

    localparam int DEPTH = `RVSEED_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    rvseed_pkg::uop_t mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    assign head  = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count >= CNT_W'(DEPTH - 1));  // one slot kept for the uop still in the decoder

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    // the source honours full, so the decoder can never overrun the last slot
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> (count < CNT_W'(DEPTH)) || pop);

    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> !empty);

endmodule

//--- hw/alu.sv
`timescale 1ns/1ps
`include "rvseed_config.svh"

module alu (
    input  rvseed_pkg::alu_op_t alu_op,
    input  rvseed_pkg::xlen_t   src1,
    input  rvseed_pkg::xlen_t   src2,
    output rvseed_pkg::xlen_t   res
);

    localparam int SHAMT_W = $clog2(`RVSEED_XLEN);

    logic [SHAMT_W-1:0] shamt;
    logic [31:0]        sum_w;

    assign shamt = src2[SHAMT_W-1:0];     // only the low bits count, as in RV64
    assign sum_w = src1[31:0] + src2[31:0];

    always_comb begin
        case (alu_op)
            rvseed_pkg::ALU_ADD:  res = src1 + src2;
            rvseed_pkg::ALU_SUB:  res = src1 - src2;
            rvseed_pkg::ALU_ADDW: res = {{(`RVSEED_XLEN-32){sum_w[31]}}, sum_w};
            rvseed_pkg::ALU_SLTU: res = rvseed_pkg::xlen_t'(src1 < src2);
            rvseed_pkg::ALU_SRA:  res = $signed(src1) >>> shamt;
            rvseed_pkg::ALU_SLL:  res = src1 << shamt;
            rvseed_pkg::ALU_AND:  res = src1 & src2;
            rvseed_pkg::ALU_XOR:  res = src1 ^ src2;
            rvseed_pkg::ALU_REMU: begin
                if (src2 == '0) begin
                    res = src1;  // divide by zero leaves the dividend
                end else begin
                    res = src1 % src2;
                end
            end
            default: res = '0;
        endcase
    end

endmodule

//--- hw/data_mem.sv
`timescale 1ns/1ps
`include "rvseed_config.svh"

module data_mem (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rvseed_pkg::xlen_t     addr,
    input  logic                  store_en,
    input  rvseed_pkg::xlen_t     store_data,
    input  rvseed_pkg::mem_size_t load_size,
    output rvseed_pkg::xlen_t     load_data
);

    localparam int WORDS = `RVSEED_DMEM_WORDS;
    localparam int IDX_W = $clog2(WORDS);

    rvseed_pkg::xlen_t mem [WORDS];
    logic [IDX_W-1:0]  idx;
    rvseed_pkg::xlen_t word;

    assign idx  = addr[3 +: IDX_W];  // address wraps modulo the memory size
    assign word = mem[idx];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (store_en) begin
            mem[idx] <= store_data;
        end
    end

    always_comb begin
        case (load_size)
            rvseed_pkg::SIZE_B: load_data = rvseed_pkg::xlen_t'(word[addr[2:0]*8 +: 8]);
            rvseed_pkg::SIZE_W: load_data = rvseed_pkg::xlen_t'(addr[2] ? word[63:32] : word[31:0]);
            rvseed_pkg::SIZE_D: load_data = word;
            default:            load_data = '0;
        endcase
    end

endmodule

//--- hw/exec_unit.sv
`timescale 1ns/1ps
`include "rvseed_config.svh"

module exec_unit (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             empty,
    input  rvseed_pkg::uop_t head,
    output logic             pop,
    output logic             wb_valid,
    output rvseed_pkg::wb_t  wb
);

    localparam int NREGS = `RVSEED_NUM_REGS;

    rvseed_pkg::exec_state_e state;
    rvseed_pkg::uop_t        cur;
    rvseed_pkg::xlen_t       regs [NREGS];
    rvseed_pkg::xlen_t       rs1_val;
    rvseed_pkg::xlen_t       rs2_val;
    rvseed_pkg::xlen_t       src2;
    rvseed_pkg::xlen_t       alu_res;
    rvseed_pkg::xlen_t       load_data;
    rvseed_pkg::xlen_t       wb_data;
    logic                    run;

    assign run     = (state == rvseed_pkg::EXEC_RUN);
    assign pop     = (state == rvseed_pkg::EXEC_IDLE) && !empty;
    assign rs1_val = (cur.rs1 == '0) ? '0 : regs[cur.rs1];  // x0 reads as zero
    assign rs2_val = (cur.rs2 == '0) ? '0 : regs[cur.rs2];
    assign src2    = cur.use_imm ? cur.imm : rs2_val;
    assign wb_data = cur.is_load ? load_data : alu_res;

    alu u_alu (
        .alu_op (cur.alu_op),
        .src1   (rs1_val),
        .src2   (src2),
        .res    (alu_res)
    );

    data_mem u_dmem (
        .clk        (clk),
        .rst_n      (rst_n),
        .addr       (alu_res),
        .store_en   (run && cur.is_store),
        .store_data (rs2_val),
        .load_size  (cur.mem_size),
        .load_data  (load_data)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= rvseed_pkg::EXEC_IDLE;
            cur      <= '0;
            wb_valid <= 1'b0;
            wb       <= '0;
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            wb_valid <= 1'b0;
            case (state)
                rvseed_pkg::EXEC_IDLE: begin
                    if (!empty) begin
                        cur   <= head;
                        state <= rvseed_pkg::EXEC_RUN;
                    end
                end
                rvseed_pkg::EXEC_RUN: begin
                    state <= rvseed_pkg::EXEC_IDLE;
                    if (cur.wr_en) begin
                        regs[cur.rd] <= wb_data;
                        wb_valid     <= 1'b1;  // result leaves one cycle after RUN
                        wb.rd        <= cur.rd;
                        wb.data      <= wb_data;
                    end
                end
                default: state <= rvseed_pkg::EXEC_IDLE;
            endcase
        end
    end

    // the decoder strips rd zero, so no write-back may ever name x0
    a_wb_not_x0: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> (wb.rd != '0));

    // a store from the decoder never carries a register write
    a_store_no_wb: assert property (@(posedge clk) disable iff (!rst_n)
        (run && cur.is_store) |-> !cur.wr_en);

endmodule

//--- hw/rvseed_exec_top.sv
`timescale 1ns/1ps

module rvseed_exec_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              inst_valid,
    input  rvseed_pkg::inst_t inst,
    output logic              full,
    output logic              illegal_inst,
    output logic              wb_valid,
    output rvseed_pkg::wb_t   wb
);

    logic             uop_valid;
    rvseed_pkg::uop_t uop;
    logic             empty;
    logic             pop;
    rvseed_pkg::uop_t head;

    inst_decoder u_dec (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .uop_valid    (uop_valid),
        .uop          (uop),
        .illegal_inst (illegal_inst)
    );

    uop_fifo u_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (uop_valid),
        .push_data (uop),
        .pop       (pop),
        .head      (head),
        .empty     (empty),
        .full      (full)
    );

    exec_unit u_exec (
        .clk      (clk),
        .rst_n    (rst_n),
        .empty    (empty),
        .head     (head),
        .pop      (pop),
        .wb_valid (wb_valid),
        .wb       (wb)
    );

endmodule

//--- testbench/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 10 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;  // released away from the active edge
    end

endmodule

//--- testbench/tb_rvseed.sv
`timescale 1ns/1ps
`include "rvseed_config.svh"

module tb_rvseed;

    localparam int NUM_INSTS   = 400;
    localparam int WAIT_LIMIT  = 100;
    localparam int DRAIN_LIMIT = 400;
    localparam int MEM_WORDS   = `RVSEED_DMEM_WORDS;
    localparam int IDX_W       = $clog2(MEM_WORDS);

    logic              clk;
    logic              rst_n;
    logic              inst_valid;
    rvseed_pkg::inst_t inst;
    logic              full;
    logic              illegal_inst;
    logic              wb_valid;
    rvseed_pkg::wb_t   wb;

    integer            seed;
    rvseed_pkg::xlen_t model_regs [`RVSEED_NUM_REGS];
    rvseed_pkg::xlen_t model_mem [MEM_WORDS];
    rvseed_pkg::wb_t   exp_q [$];
    int                illegal_pending;
    logic              saw_full;

    tb_clkgen u_clkgen (.clk(clk), .rst_n(rst_n));

    rvseed_exec_top u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .full         (full),
        .illegal_inst (illegal_inst),
        .wb_valid     (wb_valid),
        .wb           (wb)
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_wb(input rvseed_pkg::wb_t got);
        rvseed_pkg::wb_t want;
        if (exp_q.size() == 0) begin
            fail_run($sformatf("write-back to x%0d arrived with none expected", got.rd));
        end else begin
            want = exp_q.pop_front();
            if (got !== want) begin
                fail_run($sformatf("MISMATCH at %0t: write-back x%0d=%h, expected x%0d=%h",
                                   $time, got.rd, got.data, want.rd, want.data));
            end
        end
    endtask

    task automatic check_illegal();
        if (illegal_pending == 0) begin
            fail_run($sformatf("MISMATCH at %0t: illegal_inst pulse with no illegal word issued",
                               $time));
        end else begin
            illegal_pending--;
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic want);
        if (got !== want) begin
            fail_run($sformatf("MISMATCH at %0t: %s is %b, expected %b", $time, name, got, want));
        end
    endtask

    // returns on a falling edge with full low and the strobe cleared
    task automatic wait_for_room();
        int cycles;
        cycles = 0;
        @(negedge clk);
        inst_valid = 1'b0;
        while (full && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (full) begin
            fail_run("timed out waiting for full to drop");
        end
    endtask

    function automatic rvseed_pkg::inst_t encode_r(input logic [6:0] f7, input logic [2:0] f3,
                                                   input rvseed_pkg::reg_idx_t rs2,
                                                   input rvseed_pkg::reg_idx_t rs1,
                                                   input rvseed_pkg::reg_idx_t rd,
                                                   input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    // picks one instruction, runs it on the model and drives it
    task automatic issue_one();
        int unsigned          kind;
        rvseed_pkg::reg_idx_t rd;
        rvseed_pkg::reg_idx_t rs1;
        rvseed_pkg::reg_idx_t rs2;
        logic [11:0]          imm;
        rvseed_pkg::xlen_t    a;
        rvseed_pkg::xlen_t    b;
        rvseed_pkg::xlen_t    simm;
        rvseed_pkg::xlen_t    res;
        rvseed_pkg::xlen_t    word;
        rvseed_pkg::inst_t    w;
        rvseed_pkg::wb_t      exp_wb;
        logic [31:0]          sum32;
        logic [IDX_W-1:0]     idx;
        kind = $unsigned($random(seed)) % 16;
        rd   = rvseed_pkg::reg_idx_t'($unsigned($random(seed)) % 8);
        rs1  = rvseed_pkg::reg_idx_t'($unsigned($random(seed)) % 8);
        rs2  = rvseed_pkg::reg_idx_t'($unsigned($random(seed)) % 8);
        imm  = 12'($unsigned($random(seed)));
        if (kind >= 10) begin
            rs1 = '0;  // memory ops address from x0 so the address is the offset
            imm = 12'($unsigned($random(seed)) % 128);
        end
        a    = model_regs[rs1];
        b    = model_regs[rs2];
        simm = rvseed_pkg::xlen_t'($signed(imm));
        idx  = simm[3 +: IDX_W];
        word = model_mem[idx];
        res  = '0;
        if ($unsigned($random(seed)) % 100 < 5) begin
            w = $random(seed);
            w[6:0] = 7'b1010111;  // opcode outside the supported set
            illegal_pending++;
        end else begin
            case (kind)
                0: begin
                    w = {imm, rs1, 3'b000, rd, 7'b0010011};
                    res = a + simm;
                end
                1: begin
                    w = encode_r(7'b0000000, 3'b000, rs2, rs1, rd, 7'b0110011);
                    res = a + b;
                end
                2: begin
                    w = encode_r(7'b0100000, 3'b000, rs2, rs1, rd, 7'b0110011);
                    res = a - b;
                end
                3: begin
                    w = encode_r(7'b0000000, 3'b000, rs2, rs1, rd, 7'b0111011);
                    sum32 = a[31:0] + b[31:0];
                    res = 64'($signed(sum32));
                end
                4: begin
                    w = encode_r(7'b0000000, 3'b011, rs2, rs1, rd, 7'b0110011);
                    res = (a < b) ? 64'd1 : 64'd0;
                end
                5: begin
                    w = encode_r(7'b0100000, 3'b101, rs2, rs1, rd, 7'b0110011);
                    res = rvseed_pkg::xlen_t'($signed(a) >>> b[5:0]);
                end
                6: begin
                    w = encode_r(7'b0000000, 3'b111, rs2, rs1, rd, 7'b0110011);
                    res = a & b;
                end
                7: begin
                    w = encode_r(7'b0000000, 3'b100, rs2, rs1, rd, 7'b0110011);
                    res = a ^ b;
                end
                8: begin
                    w = encode_r(7'b0000000, 3'b001, rs2, rs1, rd, 7'b0110011);
                    res = a << b[5:0];
                end
                9: begin
                    w = encode_r(7'b0000001, 3'b111, rs2, rs1, rd, 7'b0110011);
                    res = (b == 64'd0) ? a : a % b;
                end
                10: begin
                    w = {imm, rs1, 3'b011, rd, 7'b0000011};
                    res = word;
                end
                11: begin
                    w = {imm, rs1, 3'b110, rd, 7'b0000011};
                    res = simm[2] ? {32'h0, word[63:32]} : {32'h0, word[31:0]};
                end
                12: begin
                    w = {imm, rs1, 3'b100, rd, 7'b0000011};
                    res = (word >> (8 * simm[2:0])) & 64'hff;
                end
                default: begin
                    w = {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'b0100011};
                    model_mem[idx] = b;
                end
            endcase
            if (kind < 13 && rd != '0) begin
                model_regs[rd] = res;
                exp_wb.rd      = rd;
                exp_wb.data    = res;
                exp_q.push_back(exp_wb);
            end
        end
        inst       = w;
        inst_valid = 1'b1;
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            if (wb_valid) begin
                check_wb(wb);
            end
            if (illegal_inst) begin
                check_illegal();
            end
            if (full) begin
                saw_full = 1'b1;
            end
        end
    end

    initial begin
        int cycles;
        seed            = 32'hd6b6461e;
        inst_valid      = 1'b0;
        inst            = '0;
        illegal_pending = 0;
        saw_full        = 1'b0;
        cycles          = 0;
        for (int i = 0; i < `RVSEED_NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            model_mem[i] = '0;
        end
        while (rst_n !== 1'b1 && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (rst_n !== 1'b1) begin
            fail_run("timed out waiting for reset to be released");
        end
        repeat (5) begin
            @(negedge clk);
            check_level("wb_valid", wb_valid, 1'b0);
            check_level("illegal_inst", illegal_inst, 1'b0);
            check_level("full", full, 1'b0);
        end
        for (int n = 0; n < NUM_INSTS; n++) begin
            wait_for_room();
            if (n < NUM_INSTS / 2) begin
                repeat ($unsigned($random(seed)) % 3) wait_for_room();  // gaps, then a burst
            end
            issue_one();
        end
        @(negedge clk);
        inst_valid = 1'b0;
        cycles = 0;
        while ((exp_q.size() != 0 || illegal_pending != 0) && cycles < DRAIN_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        repeat (10) @(negedge clk);  // room for any stray write-back to show up
        if (exp_q.size() != 0) begin
            fail_run($sformatf("timed out draining, %0d write-backs never came", exp_q.size()));
        end else if (illegal_pending != 0) begin
            fail_run($sformatf("timed out draining, %0d illegal pulses never came",
                               illegal_pending));
        end else if (!saw_full) begin
            fail_run("full never went high during the back-to-back burst");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

//--- compile.f
+incdir+include
hw/rvseed_pkg.sv
hw/inst_decoder.sv
hw/uop_fifo.sv
hw/alu.sv
hw/data_mem.sv
hw/exec_unit.sv
hw/rvseed_exec_top.sv
testbench/tb_clkgen.sv
testbench/tb_rvseed.sv

//--- Makefile
SRCS := $(filter-out +%,$(shell cat compile.f))

all: run

obj_dir/Vtb_rvseed: compile.f $(SRCS) include/rvseed_config.svh
	verilator --binary --timing -Iinclude -f compile.f --top-module tb_rvseed -o Vtb_rvseed

run: obj_dir/Vtb_rvseed
	-./obj_dir/Vtb_rvseed > sim.log 2>&1
	@cat sim.log
	@grep -qF '*** TEST PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
